//--- Bender.yml
package:
  name: innerbus

sources:
  - src/innerbus_pkg.sv
  - src/innerbus_crossbar.sv
  - src/clint_unit.sv
  - src/mem_unit.sv
  - src/innerbus_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/innerbus_props.sv
      - testbench/innerbus_tb.sv

//--- src/clint_unit.sv
//************************************************************
// core-local interruptor slave
// msip, mtimecmp, free-running mtime,
// timer and software interrupt outputs
//************************************************************

`timescale 1ns/1ps

module clint_unit (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req_valid,
	input  innerbus_pkg::bus_req_t  req,
	output innerbus_pkg::bus_data_t rsp_data,
	output logic                    rsp_valid,
	input  logic                    rsp_ready,
	output logic                    timer_irq,
	output logic                    soft_irq
);

	logic        msip_q;
	logic [63:0] mtimecmp_q;
	logic [63:0] mtime_q;
	logic        rsp_valid_q;
	innerbus_pkg::bus_data_t rsp_data_q;
	innerbus_pkg::bus_data_t rd_word;
	logic [23:0] off;
	logic        accept;

	assign off    = {req.addr[23:3], 3'b000}; // word aligned offset
	assign accept = req_valid & ~rsp_valid_q; // one request in flight

	always_comb begin
		case (off)
			innerbus_pkg::clint_msip_off:     rd_word = {63'b0, msip_q};
			innerbus_pkg::clint_mtimecmp_off: rd_word = mtimecmp_q;
			innerbus_pkg::clint_mtime_off:    rd_word = mtime_q;
			default:                          rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			msip_q     <= 1'b0;
			mtimecmp_q <= '1; // no timer interrupt until programmed
			mtime_q    <= '0;
		end else begin
			mtime_q <= mtime_q + 64'd1; // free running, writes ignored
			if (accept && req.wen) begin
				if (off == innerbus_pkg::clint_msip_off && req.wstrb[0]) begin
					msip_q <= req.data_w[0];
				end
				if (off == innerbus_pkg::clint_mtimecmp_off) begin
					mtimecmp_q <= innerbus_pkg::apply_strb(mtimecmp_q, req.data_w, req.wstrb);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid_q <= 1'b0;
		end else if (accept) begin
			rsp_valid_q <= 1'b1;
		end else if (rsp_ready) begin
			rsp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rsp_data_q <= rd_word; // value before any write
		end
	end

	assign rsp_valid = rsp_valid_q;
	assign rsp_data  = rsp_data_q;
	assign timer_irq = (mtime_q >= mtimecmp_q);
	assign soft_irq  = msip_q;

endmodule

//--- src/innerbus_crossbar.sv
//************************************************************
// inner bus crossbar
// fixed priority arbiter (dm, ifu, lsu) with owner lock,
// address decode to clint / mem / default responder,
// response and ready routing back to the owner
//************************************************************

`timescale 1ns/1ps

module innerbus_crossbar (
	input  logic                   clk,
	input  logic                   rst,

	input  logic                   dm_req_valid,
	input  innerbus_pkg::bus_req_t dm_req,
	output innerbus_pkg::bus_data_t dm_rsp_data,
	output logic                   dm_rsp_valid,
	input  logic                   dm_rsp_ready,

	input  logic                   ifu_req_valid,
	input  innerbus_pkg::bus_req_t ifu_req,
	output innerbus_pkg::bus_data_t ifu_rsp_data,
	output logic                   ifu_rsp_valid,
	input  logic                   ifu_rsp_ready,

	input  logic                   lsu_req_valid,
	input  innerbus_pkg::bus_req_t lsu_req,
	output innerbus_pkg::bus_data_t lsu_rsp_data,
	output logic                   lsu_rsp_valid,
	input  logic                   lsu_rsp_ready,

	output logic                   clint_req_valid,
	output innerbus_pkg::bus_req_t clint_req,
	input  innerbus_pkg::bus_data_t clint_rsp_data,
	input  logic                   clint_rsp_valid,
	output logic                   clint_rsp_ready,

	output logic                   mem_req_valid,
	output innerbus_pkg::bus_req_t mem_req,
	input  innerbus_pkg::bus_data_t mem_rsp_data,
	input  logic                   mem_rsp_valid,
	output logic                   mem_rsp_ready
);

	localparam int req_w = $bits(innerbus_pkg::bus_req_t);

	logic [innerbus_pkg::n_masters-1:0] req_vec, rdy_vec;
	logic [innerbus_pkg::n_masters-1:0] grant, owner, owner_q;
	innerbus_pkg::bus_req_t  act_req;
	innerbus_pkg::bus_data_t rsp_data_sel;
	logic act_valid, act_ready, rsp_valid_sel, done;
	logic sel_clint, sel_mem, sel_dflt;
	logic dflt_rsp_valid_q;

	assign req_vec[innerbus_pkg::dm_idx]  = dm_req_valid;
	assign req_vec[innerbus_pkg::ifu_idx] = ifu_req_valid;
	assign req_vec[innerbus_pkg::lsu_idx] = lsu_req_valid;
	assign rdy_vec[innerbus_pkg::dm_idx]  = dm_rsp_ready;
	assign rdy_vec[innerbus_pkg::ifu_idx] = ifu_rsp_ready;
	assign rdy_vec[innerbus_pkg::lsu_idx] = lsu_rsp_ready;

	assign grant = req_vec & (~req_vec + 1'b1); // lowest set bit
	assign owner = (owner_q != '0) ? owner_q : grant; // locked owner, else fresh grant

	assign act_req = ({req_w{owner[innerbus_pkg::dm_idx]}} & dm_req)
		| ({req_w{owner[innerbus_pkg::ifu_idx]}} & ifu_req)
		| ({req_w{owner[innerbus_pkg::lsu_idx]}} & lsu_req);
	assign act_valid = |(owner & req_vec);
	assign act_ready = |(owner & rdy_vec);

	// address decode on the owner's request
	assign sel_clint = innerbus_pkg::in_region(act_req.addr, innerbus_pkg::clint_base,
		innerbus_pkg::clint_mask);
	assign sel_mem = innerbus_pkg::in_region(act_req.addr, innerbus_pkg::mem_base,
		innerbus_pkg::mem_mask);
	assign sel_dflt = ~(sel_clint | sel_mem); // plic/sysbus/perip/unmapped

	assign clint_req_valid = act_valid & sel_clint;
	assign clint_req       = act_req;
	assign clint_rsp_ready = act_ready & sel_clint;
	assign mem_req_valid   = act_valid & sel_mem;
	assign mem_req         = act_req;
	assign mem_rsp_ready   = act_ready & sel_mem;

	// default responder, zero data one cycle after selection
	always_ff @(posedge clk) begin
		if (rst) begin
			dflt_rsp_valid_q <= 1'b0;
		end else if (dflt_rsp_valid_q) begin
			dflt_rsp_valid_q <= ~act_ready;
		end else begin
			dflt_rsp_valid_q <= act_valid & sel_dflt;
		end
	end

	assign rsp_valid_sel = (sel_clint & clint_rsp_valid) | (sel_mem & mem_rsp_valid)
		| (sel_dflt & dflt_rsp_valid_q);
	assign rsp_data_sel = ({64{sel_clint & clint_rsp_valid}} & clint_rsp_data)
		| ({64{sel_mem & mem_rsp_valid}} & mem_rsp_data);
	assign done = rsp_valid_sel & act_ready;

	// owner lock, released at the completing edge
	always_ff @(posedge clk) begin
		if (rst || done) begin
			owner_q <= '0;
		end else begin
			owner_q <= owner;
		end
	end

	assign dm_rsp_valid  = rsp_valid_sel & owner[innerbus_pkg::dm_idx];
	assign ifu_rsp_valid = rsp_valid_sel & owner[innerbus_pkg::ifu_idx];
	assign lsu_rsp_valid = rsp_valid_sel & owner[innerbus_pkg::lsu_idx];
	assign dm_rsp_data   = {64{owner[innerbus_pkg::dm_idx]}} & rsp_data_sel;
	assign ifu_rsp_data  = {64{owner[innerbus_pkg::ifu_idx]}} & rsp_data_sel;
	assign lsu_rsp_data  = {64{owner[innerbus_pkg::lsu_idx]}} & rsp_data_sel;

endmodule

//--- src/innerbus_pkg.sv
//************************************************************
// inner bus shared definitions
// request struct, read data word, master indices,
// region map and clint register offsets,
// region match and byte strobe merge helpers
//************************************************************

package innerbus_pkg;

	typedef struct packed {
		logic [63:0] addr;
		logic [63:0] data_w;
		logic [7:0]  wstrb;
		logic        wen;
	} bus_req_t;

	typedef logic [63:0] bus_data_t;

	// lower index wins arbitration
	localparam int n_masters = 3;
	localparam int dm_idx    = 0;
	localparam int ifu_idx   = 1;
	localparam int lsu_idx   = 2;

	localparam logic [63:0] clint_base  = 64'h0200_0000; // 0x0200_0000..0x02ff_ffff
	localparam logic [63:0] clint_mask  = 64'h00ff_ffff;
	localparam logic [63:0] plic_base   = 64'h0300_0000; // no plic, default responder
	localparam logic [63:0] plic_mask   = 64'h00ff_ffff;
	localparam logic [63:0] perip_base  = 64'h2000_0000; // 0x2000_0000..0x3fff_ffff
	localparam logic [63:0] perip_mask  = 64'h1fff_ffff;
	localparam logic [63:0] sysbus_base = 64'h4000_0000; // 0x4000_0000..0x7fff_ffff
	localparam logic [63:0] sysbus_mask = 64'h3fff_ffff;
	localparam logic [63:0] mem_base    = 64'h8000_0000; // 0x8000_0000..0xffff_ffff
	localparam logic [63:0] mem_mask    = 64'h7fff_ffff;

	// offsets inside the clint region
	localparam logic [23:0] clint_msip_off     = 24'h00_0000;
	localparam logic [23:0] clint_mtimecmp_off = 24'h00_4000;
	localparam logic [23:0] clint_mtime_off    = 24'h00_bff8;

	function automatic logic in_region(logic [63:0] addr, logic [63:0] base, logic [63:0] mask);
		return (addr | mask) == (base | mask);
	endfunction

	function automatic bus_data_t apply_strb(bus_data_t old_word, bus_data_t new_word,
		logic [7:0] strb);
		bus_data_t merged;
		merged = old_word;
		for (int i = 0; i < 8; i++) begin
			if (strb[i]) begin
				merged[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return merged;
	endfunction

endpackage

//--- src/innerbus_top.sv
//************************************************************
// inner bus top
// crossbar with clint and memory slaves
//************************************************************

`timescale 1ns/1ps

module innerbus_top #(
	parameter int mem_words = 256
) (
	input  logic                    clk,
	input  logic                    rst,

	input  logic                    dm_req_valid,
	input  innerbus_pkg::bus_req_t  dm_req,
	output innerbus_pkg::bus_data_t dm_rsp_data,
	output logic                    dm_rsp_valid,
	input  logic                    dm_rsp_ready,

	input  logic                    ifu_req_valid,
	input  innerbus_pkg::bus_req_t  ifu_req,
	output innerbus_pkg::bus_data_t ifu_rsp_data,
	output logic                    ifu_rsp_valid,
	input  logic                    ifu_rsp_ready,

	input  logic                    lsu_req_valid,
	input  innerbus_pkg::bus_req_t  lsu_req,
	output innerbus_pkg::bus_data_t lsu_rsp_data,
	output logic                    lsu_rsp_valid,
	input  logic                    lsu_rsp_ready,

	output logic                    timer_irq,
	output logic                    soft_irq
);

	logic                    clint_req_valid, clint_rsp_valid, clint_rsp_ready;
	innerbus_pkg::bus_req_t  clint_req;
	innerbus_pkg::bus_data_t clint_rsp_data;
	logic                    mem_req_valid, mem_rsp_valid, mem_rsp_ready;
	innerbus_pkg::bus_req_t  mem_req;
	innerbus_pkg::bus_data_t mem_rsp_data;

	innerbus_crossbar i_crossbar (
		.clk             (clk),
		.rst             (rst),
		.dm_req_valid    (dm_req_valid),
		.dm_req          (dm_req),
		.dm_rsp_data     (dm_rsp_data),
		.dm_rsp_valid    (dm_rsp_valid),
		.dm_rsp_ready    (dm_rsp_ready),
		.ifu_req_valid   (ifu_req_valid),
		.ifu_req         (ifu_req),
		.ifu_rsp_data    (ifu_rsp_data),
		.ifu_rsp_valid   (ifu_rsp_valid),
		.ifu_rsp_ready   (ifu_rsp_ready),
		.lsu_req_valid   (lsu_req_valid),
		.lsu_req         (lsu_req),
		.lsu_rsp_data    (lsu_rsp_data),
		.lsu_rsp_valid   (lsu_rsp_valid),
		.lsu_rsp_ready   (lsu_rsp_ready),
		.clint_req_valid (clint_req_valid),
		.clint_req       (clint_req),
		.clint_rsp_data  (clint_rsp_data),
		.clint_rsp_valid (clint_rsp_valid),
		.clint_rsp_ready (clint_rsp_ready),
		.mem_req_valid   (mem_req_valid),
		.mem_req         (mem_req),
		.mem_rsp_data    (mem_rsp_data),
		.mem_rsp_valid   (mem_rsp_valid),
		.mem_rsp_ready   (mem_rsp_ready)
	);

	clint_unit i_clint (
		.clk       (clk),
		.rst       (rst),
		.req_valid (clint_req_valid),
		.req       (clint_req),
		.rsp_data  (clint_rsp_data),
		.rsp_valid (clint_rsp_valid),
		.rsp_ready (clint_rsp_ready),
		.timer_irq (timer_irq),
		.soft_irq  (soft_irq)
	);

	mem_unit #(
		.mem_words (mem_words)
	) i_mem (
		.clk       (clk),
		.rst       (rst),
		.req_valid (mem_req_valid),
		.req       (mem_req),
		.rsp_data  (mem_rsp_data),
		.rsp_valid (mem_rsp_valid),
		.rsp_ready (mem_rsp_ready)
	);

endmodule

//--- src/mem_unit.sv
//************************************************************
// word memory slave
// byte strobed writes, registered read word,
// response one cycle after acceptance
//************************************************************

`timescale 1ns/1ps

module mem_unit #(
	parameter int mem_words = 256
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req_valid,
	input  innerbus_pkg::bus_req_t  req,
	output innerbus_pkg::bus_data_t rsp_data,
	output logic                    rsp_valid,
	input  logic                    rsp_ready
);

	localparam int aw = $clog2(mem_words);

	innerbus_pkg::bus_data_t mem_q [mem_words];
	innerbus_pkg::bus_data_t rsp_data_q;
	logic          rsp_valid_q;
	logic [aw-1:0] idx;
	logic          accept;

	assign idx    = req.addr[aw+2:3]; // wraps modulo mem_words
	assign accept = req_valid & ~rsp_valid_q;

	always_ff @(posedge clk) begin
		if (accept) begin
			rsp_data_q <= mem_q[idx]; // old word on a write
			if (req.wen) begin
				mem_q[idx] <= innerbus_pkg::apply_strb(mem_q[idx], req.data_w, req.wstrb);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid_q <= 1'b0;
		end else if (accept) begin
			rsp_valid_q <= 1'b1;
		end else if (rsp_ready) begin
			rsp_valid_q <= 1'b0;
		end
	end

	assign rsp_valid = rsp_valid_q;
	assign rsp_data  = rsp_data_q;

endmodule

//--- testbench/innerbus_props.sv
//************************************************************
// inner bus protocol properties
// one master response, one slave request, response only
// under a held request, stable owner, bound into the crossbar
//************************************************************

`timescale 1ns/1ps

module innerbus_props (
	input logic                               clk,
	input logic                               rst,
	input logic                               dm_req_valid,
	input logic                               ifu_req_valid,
	input logic                               lsu_req_valid,
	input logic                               dm_rsp_valid,
	input logic                               ifu_rsp_valid,
	input logic                               lsu_rsp_valid,
	input logic                               clint_req_valid,
	input logic                               mem_req_valid,
	input logic [innerbus_pkg::n_masters-1:0] owner,
	input logic                               done
);

	int fail_count = 0; // read by the testbench at the end

	a_one_rsp: assert property (@(posedge clk) disable iff (rst)
		$onehot0({dm_rsp_valid, ifu_rsp_valid, lsu_rsp_valid}))
		else begin
			fail_count++;
			$error("more than one master sees rsp_valid");
		end

	a_one_slave: assert property (@(posedge clk) disable iff (rst)
		!(clint_req_valid && mem_req_valid))
		else begin
			fail_count++;
			$error("clint and mem requested in the same cycle");
		end

	// response only to a master still holding its request
	a_rsp_held: assert property (@(posedge clk) disable iff (rst)
		(!dm_rsp_valid || dm_req_valid) && (!ifu_rsp_valid || ifu_req_valid)
		&& (!lsu_rsp_valid || lsu_req_valid))
		else begin
			fail_count++;
			$error("rsp_valid without a pending request");
		end

	a_owner_stable: assert property (@(posedge clk) disable iff (rst)
		(owner != '0 && !done) |=> (owner == $past(owner)))
		else begin
			fail_count++;
			$error("owner changed while a transfer was pending");
		end

endmodule

bind innerbus_crossbar innerbus_props i_props (
	.clk             (clk),
	.rst             (rst),
	.dm_req_valid    (dm_req_valid),
	.ifu_req_valid   (ifu_req_valid),
	.lsu_req_valid   (lsu_req_valid),
	.dm_rsp_valid    (dm_rsp_valid),
	.ifu_rsp_valid   (ifu_rsp_valid),
	.lsu_rsp_valid   (lsu_rsp_valid),
	.clint_req_valid (clint_req_valid),
	.mem_req_valid   (mem_req_valid),
	.owner           (owner),
	.done            (done)
);

//--- testbench/innerbus_tb.sv
//************************************************************
// inner bus testbench
// random traffic from dm, ifu and lsu, memory and clint model,
// timer / soft interrupt, priority and back-pressure checks,
// watchdog and closing report
//************************************************************

`timescale 1ns/1ps

module innerbus_tb;

	localparam int mem_words  = 256;
	localparam int n_xfers    = 120; // per master
	localparam int xfer_bound = 48;  // worst case cycles per transfer
	localparam int timeout_ns = (innerbus_pkg::n_masters * n_xfers + 32) * xfer_bound * 4;

	logic clk, rst;
	logic [2:0] req_valid, rsp_ready, rsp_valid;
	innerbus_pkg::bus_req_t [2:0] req;
	logic [2:0][63:0] rsp_data;
	logic timer_irq, soft_irq;

	// reference model
	logic [63:0] shadow [mem_words];
	logic [7:0]  known [mem_words];
	logic        msip_m;
	logic [63:0] mtimecmp_m;
	logic [63:0] last_mtime [3];

	logic [31:0] rng [3];
	int done_order [3];
	int done_count, errors, checks;

	tb_clock_gen i_clock (.clk(clk), .rst(rst));

	innerbus_top #(
		.mem_words (mem_words)
	) i_dut (
		.clk           (clk),
		.rst           (rst),
		.dm_req_valid  (req_valid[innerbus_pkg::dm_idx]),
		.dm_req        (req[innerbus_pkg::dm_idx]),
		.dm_rsp_data   (rsp_data[innerbus_pkg::dm_idx]),
		.dm_rsp_valid  (rsp_valid[innerbus_pkg::dm_idx]),
		.dm_rsp_ready  (rsp_ready[innerbus_pkg::dm_idx]),
		.ifu_req_valid (req_valid[innerbus_pkg::ifu_idx]),
		.ifu_req       (req[innerbus_pkg::ifu_idx]),
		.ifu_rsp_data  (rsp_data[innerbus_pkg::ifu_idx]),
		.ifu_rsp_valid (rsp_valid[innerbus_pkg::ifu_idx]),
		.ifu_rsp_ready (rsp_ready[innerbus_pkg::ifu_idx]),
		.lsu_req_valid (req_valid[innerbus_pkg::lsu_idx]),
		.lsu_req       (req[innerbus_pkg::lsu_idx]),
		.lsu_rsp_data  (rsp_data[innerbus_pkg::lsu_idx]),
		.lsu_rsp_valid (rsp_valid[innerbus_pkg::lsu_idx]),
		.lsu_rsp_ready (rsp_ready[innerbus_pkg::lsu_idx]),
		.timer_irq     (timer_irq),
		.soft_irq      (soft_irq)
	);

	function automatic logic [31:0] rand_word(input int m);
		rng[m] = rng[m] * 32'd1664525 + 32'd1013904223; // per master lcg
		return rng[m];
	endfunction

	function automatic string master_name(input int m);
		case (m)
			innerbus_pkg::dm_idx:  return "dm";
			innerbus_pkg::ifu_idx: return "ifu";
			default:               return "lsu";
		endcase
	endfunction

	function automatic innerbus_pkg::bus_req_t mk_req(input logic [63:0] addr,
		input logic [63:0] data, input logic [7:0] strb, input logic wen);
		innerbus_pkg::bus_req_t r;
		r.addr   = addr;
		r.data_w = data;
		r.wstrb  = strb;
		r.wen    = wen;
		return r;
	endfunction

	function automatic innerbus_pkg::bus_req_t make_req(input int m);
		innerbus_pkg::bus_req_t r;
		logic [31:0] a, b, c, d;
		logic [23:0] off;
		a = rand_word(m);
		b = rand_word(m);
		c = rand_word(m);
		d = rand_word(m);
		r = mk_req('0, {b, c}, a[15:8], a[4]);
		case (a[2:0])
			3'd4, 3'd5: begin
				case (d[2:0])
					3'd0, 3'd1: off = innerbus_pkg::clint_msip_off;
					3'd2, 3'd3: off = innerbus_pkg::clint_mtimecmp_off;
					3'd4, 3'd5: begin
						off   = innerbus_pkg::clint_mtime_off;
						r.wen = 1'b0; // mtime is only read
					end
					default: off = 24'h8; // hole in the clint map
				endcase
				r.addr = innerbus_pkg::clint_base + off;
			end
			3'd6, 3'd7: begin
				case (d[1:0])
					2'd0: r.addr = innerbus_pkg::plic_base + {d[23:3], 3'b0};
					2'd1: r.addr = innerbus_pkg::perip_base + {d[28:3], 3'b0};
					2'd2: r.addr = innerbus_pkg::sysbus_base + {d[29:3], 3'b0};
					default: r.addr = 64'h1_0000_0000 + {d[31:3], 3'b0}; // unmapped
				endcase
			end
			default: begin
				// aliased words wrap modulo mem_words
				r.addr = innerbus_pkg::mem_base + 64'(d[5:0]) * 8 + 64'(d[9:8]) * mem_words * 8;
			end
		endcase
		return r;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error @ %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	// model update and read check at the completing cycle
	task automatic check_rsp(input int m, input innerbus_pkg::bus_req_t r,
		input logic [63:0] rd);
		string nm;
		int idx;
		logic [63:0] bmask;
		logic [23:0] off;
		nm  = {master_name(m), "_rsp_data"};
		off = {r.addr[23:3], 3'b000};
		if (r.addr[63:31] == 33'd1) begin
			idx = int'((r.addr >> 3) % mem_words);
			for (int b = 0; b < 8; b++) begin
				bmask[8*b +: 8] = {8{known[idx][b]}};
			end
			if (!r.wen) begin
				check_value(nm, rd & bmask, shadow[idx] & bmask);
			end else begin
				for (int b = 0; b < 8; b++) begin
					if (r.wstrb[b]) begin
						shadow[idx][8*b +: 8] = r.data_w[8*b +: 8];
						known[idx][b] = 1'b1;
					end
				end
			end
		end else if (r.addr[63:24] == 40'h02) begin
			if (!r.wen) begin
				case (off)
					24'h00_0000: check_value(nm, rd, {63'b0, msip_m});
					24'h00_4000: check_value(nm, rd, mtimecmp_m);
					24'h00_bff8: begin
						checks++;
						assert (rd > last_mtime[m]) else begin
							errors++;
							$display("** Error @ %0t ns: %s = 0x%h, expected above 0x%h",
								$time, nm, rd, last_mtime[m]);
						end
						last_mtime[m] = rd;
					end
					default: check_value(nm, rd, '0);
				endcase
			end else begin
				if (off == 24'h00_0000 && r.wstrb[0]) begin
					msip_m = r.data_w[0];
				end
				if (off == 24'h00_4000) begin
					for (int b = 0; b < 8; b++) begin
						if (r.wstrb[b]) mtimecmp_m[8*b +: 8] = r.data_w[8*b +: 8];
					end
				end
			end
			check_value("soft_irq", soft_irq, msip_m);
		end else if (!r.wen) begin
			check_value(nm, rd, '0); // default responder
		end
	endtask

	// one transfer, with rsp_ready held low for the first stall response cycles
	task automatic run_xfer(input int m, input innerbus_pkg::bus_req_t r, input int stall,
		output logic [63:0] rdata);
		logic [63:0] held;
		logic seen, got;
		int left;
		seen = 1'b0;
		got  = 1'b0;
		held = '0;
		left = stall;
		@(posedge clk);
		req_valid[m] <= 1'b1;
		req[m]       <= r;
		rsp_ready[m] <= (left == 0);
		while (!got) begin
			@(negedge clk);
			if (rsp_valid[m]) begin
				if (seen) begin
					check_value({master_name(m), "_rsp_data"}, rsp_data[m], held); // stable
				end
				seen = 1'b1;
				held = rsp_data[m];
				got  = rsp_ready[m];
				left--;
			end
			if (!got) begin
				@(posedge clk);
				rsp_ready[m] <= (left <= 0);
			end
		end
		rdata = held;
		done_order[m] = done_count;
		done_count++;
		check_rsp(m, r, rdata);
		@(posedge clk);
		req_valid[m] <= 1'b0;
		rsp_ready[m] <= 1'b0;
	endtask

	task automatic run_master(input int m);
		innerbus_pkg::bus_req_t r;
		logic [63:0] rd;
		logic [31:0] s;
		for (int i = 0; i < n_xfers; i++) begin
			s = rand_word(m);
			r = make_req(m);
			repeat (int'(s[1:0])) @(posedge clk); // idle gap
			run_xfer(m, r, s[4] ? int'(s[7:5]) : 0, rd);
		end
	endtask

	// no two masters may see a response at once
	always @(negedge clk) begin
		if (!rst) begin
			assert ((rsp_valid & (rsp_valid - 3'd1)) == 3'd0) else begin
				errors++;
				$display("more than one master sees rsp_valid at %0t ns (%b)", $time, rsp_valid);
			end
		end
	end

	initial begin
		#(timeout_ns);
		$display("timeout after %0d ns, bus transfers did not finish", timeout_ns);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		innerbus_pkg::bus_req_t r0, r1, r2;
		logic [63:0] d0, d1, d2;
		req_valid  = '0;
		req        = '0;
		rsp_ready  = '0;
		errors     = 0;
		checks     = 0;
		done_count = 0;
		msip_m     = 1'b0;
		mtimecmp_m = '1;
		for (int m = 0; m < 3; m++) begin
			rng[m] = 32'hb5086cd5 + m;
			last_mtime[m] = '0;
		end
		for (int i = 0; i < mem_words; i++) begin
			known[i]  = '0;
			shadow[i] = '0;
		end

		while (rst) @(negedge clk);
		@(negedge clk);
		check_value("rsp_valid", rsp_valid, '0); // quiet after reset
		check_value("timer_irq", timer_irq, '0);
		check_value("soft_irq", soft_irq, '0);

		fork
			run_master(innerbus_pkg::dm_idx);
			run_master(innerbus_pkg::ifu_idx);
			run_master(innerbus_pkg::lsu_idx);
		join

		// timer and software interrupts
		r0 = mk_req(innerbus_pkg::clint_base + innerbus_pkg::clint_mtimecmp_off, '0, 8'hff, 1);
		run_xfer(innerbus_pkg::dm_idx, r0, 0, d0);
		@(negedge clk);
		check_value("timer_irq", timer_irq, 1);
		r0.data_w = '1;
		run_xfer(innerbus_pkg::dm_idx, r0, 0, d0);
		@(negedge clk);
		check_value("timer_irq", timer_irq, 0);
		r0 = mk_req(innerbus_pkg::clint_base + innerbus_pkg::clint_msip_off, 64'd1, 8'h01, 1);
		run_xfer(innerbus_pkg::dm_idx, r0, 0, d0);
		r0.data_w = '0;
		run_xfer(innerbus_pkg::dm_idx, r0, 0, d0);

		// all three request in one idle cycle
		r0 = mk_req(innerbus_pkg::mem_base + 64'h18, '0, '0, 0);
		r1 = mk_req(innerbus_pkg::clint_base + innerbus_pkg::clint_mtimecmp_off, '0, '0, 0);
		r2 = mk_req(innerbus_pkg::sysbus_base + 64'h100, '0, '0, 0);
		fork
			run_xfer(innerbus_pkg::dm_idx, r0, 0, d0);
			run_xfer(innerbus_pkg::ifu_idx, r1, 0, d1);
			run_xfer(innerbus_pkg::lsu_idx, r2, 0, d2);
		join
		checks++;
		assert (done_order[0] < done_order[1] && done_order[1] < done_order[2]) else begin
			errors++;
			$display("completion order dm %0d, ifu %0d, lsu %0d is not dm, ifu, lsu",
				done_order[0], done_order[1], done_order[2]);
		end

		repeat (4) @(posedge clk);
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			i_dut.i_crossbar.i_props.fail_count);
		if (errors == 0 && i_dut.i_crossbar.i_props.fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- testbench/tb_clock_gen.sv
//************************************************************
// testbench clock and reset
// 4 ns clock, reset held high for the first 16 cycles
//************************************************************

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int rst_cycles = 16
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (rst_cycles) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- verilog.f
src/innerbus_pkg.sv
src/innerbus_crossbar.sv
src/clint_unit.sv
src/mem_unit.sv
src/innerbus_top.sv
testbench/tb_clock_gen.sv
testbench/innerbus_props.sv
testbench/innerbus_tb.sv
